//--- acq/la_acq.sv
// acquisition FSM, pre-trigger count, arm, trigger, post-trigger count
// samples are forwarded from the cycle after str until the record ends
// a sample in the same cycle as stp or rst is dropped and no lst is given
// pre status counts samples before the trigger sample and pst those after it

`timescale 1ns/1ns

module la_acq import la_pkg::*; (
  input  logic     bus,
  input  logic     rst,
  input  evn_t     evn,
  input  cfg_t     cfg,
  input  trg_str_t sti,
  output out_str_t sto,
  output sts_t     sts
);

  acq_state_t state;

  // status counters and pre overflow flag
  cnt_t pre_cnt;
  cnt_t pst_cnt;
  logic pre_ovf;

  // software trigger waiting for the next sample
  logic swp;

  logic fwd;
  logic trig;
  logic last;
  cnt_t pre_nxt;
  cnt_t pst_nxt;

  assign pre_nxt = pre_cnt + cnt_t'(1);
  assign pst_nxt = pst_cnt + cnt_t'(1);

  always_comb begin
    // forward any sample inside a record unless stopping now
    fwd  = sti.vld && (state != ACQ_IDLE) && !(evn.stp || evn.rst);
    // hw trigger needs trg_ena and sw trigger takes the next sample
    trig = fwd && (state == ACQ_ARM) && ((sti.trg && cfg.trg_ena) || swp);
    last = (trig && (cfg.pst == '0))
        || (fwd && (state == ACQ_POST) && (pst_nxt == cfg.pst));
  end

  ////////////////////////////////////////////////////////////////////////////
  // state machine
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge bus) begin
    if (rst || evn.rst) begin
      state   <= ACQ_IDLE;
      swp     <= 1'b0;
      pre_cnt <= '0;
      pst_cnt <= '0;
      pre_ovf <= 1'b0;
    end else if (evn.stp) begin
      // abort while the counters keep their values for readback
      state <= ACQ_IDLE;
      swp   <= 1'b0;
    end else begin
      case (state)
        ACQ_IDLE: begin
          if (evn.str) begin
            state   <= (cfg.pre == '0) ? ACQ_ARM : ACQ_PRE;
            pre_cnt <= '0;
            pst_cnt <= '0;
            pre_ovf <= 1'b0;
          end
        end
        ACQ_PRE: begin
          // pre_cnt stays below cfg.pre here so no saturation
          if (fwd) begin
            pre_cnt <= pre_nxt;
            if (pre_nxt == cfg.pre) begin
              state <= ACQ_ARM;
            end
          end
        end
        ACQ_ARM: begin
          if (trig) begin
            swp   <= 1'b0;
            state <= (cfg.pst == '0) ? ACQ_IDLE : ACQ_POST;
          end else begin
            if (evn.swt) begin
              swp <= 1'b1;
            end
            // waiting samples still count as pre-trigger
            if (fwd) begin
              if (pre_cnt == '1) begin
                pre_ovf <= 1'b1;
              end else begin
                pre_cnt <= pre_nxt;
              end
            end
          end
        end
        ACQ_POST: begin
          // post count ends at cfg.pst and never reaches all ones
          if (fwd) begin
            pst_cnt <= pst_nxt;
            if (pst_nxt == cfg.pst) begin
              state <= ACQ_IDLE;
            end
          end
        end
        default: state <= ACQ_IDLE;
      endcase
    end
  end

  // registered output beat
  always_ff @(posedge bus) begin
    sto.data <= sti.data;
    if (rst) begin
      sto.vld <= 1'b0;
      sto.lst <= 1'b0;
    end else begin
      sto.vld <= fwd;
      sto.lst <= last;
    end
  end

  // post overflow flag stays clear
  assign sts = '{state: state, pre: pre_cnt, pro: pre_ovf, pst: pst_cnt, pso: 1'b0};

endmodule

//--- common/la_pkg.sv
// shared widths, bus/stream structs and register map of the logic analyzer
// streams carry a valid strobe only, consumers take every beat
// bus offsets are byte addresses, only ADR_W low bits are decoded

package la_pkg;

  // widths
  localparam int unsigned SMP_W = 8;
  localparam int unsigned CNT_W = 31;
  localparam int unsigned DEC_W = 17;
  localparam int unsigned ADR_W = 7;

  typedef logic [SMP_W-1:0] smp_t;
  typedef logic [CNT_W-1:0] cnt_t;
  typedef logic [DEC_W-1:0] dec_t;
  typedef logic [32-1:0]    word_t;
  typedef logic [ADR_W-1:0] adr_t;

  // register map
  localparam adr_t REG_CTL  = 7'h00;
  localparam adr_t REG_TEN  = 7'h04;
  localparam adr_t REG_PRE  = 7'h10;
  localparam adr_t REG_PST  = 7'h14;
  localparam adr_t REG_SPRE = 7'h18;
  localparam adr_t REG_SPST = 7'h1c;
  localparam adr_t REG_CMSK = 7'h20;
  localparam adr_t REG_CVAL = 7'h24;
  localparam adr_t REG_EPOS = 7'h28;
  localparam adr_t REG_ENEG = 7'h2c;
  localparam adr_t REG_DEC  = 7'h30;
  localparam adr_t REG_MSK  = 7'h40;
  localparam adr_t REG_POL  = 7'h44;

  // control events, bit 0 is rst up to bit 3 swt (matches REG_CTL write bits)
  typedef struct packed {
    logic swt;
    logic stp;
    logic str;
    logic rst;
  } evn_t;

  typedef struct packed {
    adr_t  addr;
    word_t wdata;
    logic  wen;
    logic  ren;
  } bus_req_t;

  typedef struct packed {
    word_t rdata;
    logic  ack;
  } bus_rsp_t;

  // stream beats
  typedef struct packed {
    smp_t data;
    logic vld;
  } smp_str_t;

  typedef struct packed {
    smp_t data;
    logic trg;
    logic vld;
  } trg_str_t;

  typedef struct packed {
    smp_t data;
    logic lst;
    logic vld;
  } out_str_t;

  typedef struct packed {
    dec_t dec;
    smp_t msk;
    smp_t pol;
    smp_t cmp_msk;
    smp_t cmp_val;
    smp_t edg_pos;
    smp_t edg_neg;
    logic trg_ena;
    cnt_t pre;
    cnt_t pst;
  } cfg_t;

  typedef enum logic [1:0] {
    ACQ_IDLE = 2'd0,
    ACQ_PRE  = 2'd1,
    ACQ_ARM  = 2'd2,
    ACQ_POST = 2'd3
  } acq_state_t;

  // status, counters saturate and raise their overflow flag
  typedef struct packed {
    acq_state_t state;
    cnt_t       pre;
    logic       pro;
    cnt_t       pst;
    logic       pso;
  } sts_t;

endpackage

//--- hdl/la.sv
// logic analyzer top, register bank plus decimator, trigger and acquisition
// sti to sto latency is 3 cycles for a forwarded sample
// no back-pressure, the consumer must take every sto beat

`timescale 1ns/1ns

module la import la_pkg::*; (
  input  logic     bus,
  input  logic     rst,
  input  bus_req_t bus_req,
  output bus_rsp_t bus_rsp,
  input  smp_str_t sti,
  output out_str_t sto,
  output logic     irq
);

  cfg_t     cfg;
  evn_t     evn;
  sts_t     sts;

  // decimated and conditioned stream
  smp_str_t std;
  // conditioned stream with trigger flag
  trg_str_t stt;

  ////////////////////////////////////////////////////////////////////////////
  // register bank
  ////////////////////////////////////////////////////////////////////////////

  la_regs regs (
    .bus     (bus),
    .rst     (rst),
    .bus_req (bus_req),
    .bus_rsp (bus_rsp),
    .sts     (sts),
    .lst     (sto.lst),
    .cfg     (cfg),
    .evn     (evn),
    .irq     (irq)
  );

  ////////////////////////////////////////////////////////////////////////////
  // stream path
  ////////////////////////////////////////////////////////////////////////////

  la_dec dec (
    .bus (bus),
    .rst (rst),
    .evn (evn),
    .cfg (cfg),
    .sti (sti),
    .sto (std)
  );

  la_trigger trigger (
    .bus (bus),
    .rst (rst),
    .evn (evn),
    .cfg (cfg),
    .sti (std),
    .sto (stt)
  );

  la_acq acq (
    .bus (bus),
    .rst (rst),
    .evn (evn),
    .cfg (cfg),
    .sti (stt),
    .sto (sto),
    .sts (sts)
  );

endmodule

//--- hdl/la_dec.sv
// decimator with bitwise mask and polarity
// first valid sample after reset or rst event passes, then one in dec+1
// output beat is registered, one cycle latency

`timescale 1ns/1ns

module la_dec import la_pkg::*; (
  input  logic     bus,
  input  logic     rst,
  input  evn_t     evn,
  input  cfg_t     cfg,
  input  smp_str_t sti,
  output smp_str_t sto
);

  // samples still to skip before the next pass
  dec_t cnt;
  logic pass;

  assign pass = sti.vld && (cnt == '0);

  always_ff @(posedge bus) begin
    // data only loaded on a passed sample
    if (pass) begin
      sto.data <= (sti.data & cfg.msk) ^ cfg.pol;
    end
    if (rst || evn.rst) begin
      cnt     <= '0;
      sto.vld <= 1'b0;
    end else begin
      sto.vld <= pass;
      if (sti.vld) begin
        // reload on pass, otherwise count down
        if (pass) begin
          cnt <= cfg.dec;
        end else begin
          cnt <= cnt - 1'b1;
        end
      end
    end
  end

endmodule

//--- hdl/la_regs.sv
// register bank of the logic analyzer
// ack follows wen or ren by one cycle, read data is valid in the ack cycle
// REG_CTL writes are not stored, they only produce one-cycle events
// unmapped addresses read as zero

`timescale 1ns/1ns

module la_regs import la_pkg::*; (
  input  logic     bus,
  input  logic     rst,
  input  bus_req_t bus_req,
  output bus_rsp_t bus_rsp,
  input  sts_t     sts,
  input  logic     lst,
  output cfg_t     cfg,
  output evn_t     evn,
  output logic     irq
);

  ////////////////////////////////////////////////////////////////////////////
  // write side
  ////////////////////////////////////////////////////////////////////////////

  // configuration registers, all clear on reset
  always_ff @(posedge bus) begin
    if (rst) begin
      cfg <= '0;
    end else if (bus_req.wen) begin
      case (bus_req.addr)
        REG_TEN:  cfg.trg_ena <= bus_req.wdata[0];
        REG_PRE:  cfg.pre     <= bus_req.wdata[CNT_W-1:0];
        REG_PST:  cfg.pst     <= bus_req.wdata[CNT_W-1:0];
        REG_CMSK: cfg.cmp_msk <= bus_req.wdata[SMP_W-1:0];
        REG_CVAL: cfg.cmp_val <= bus_req.wdata[SMP_W-1:0];
        REG_EPOS: cfg.edg_pos <= bus_req.wdata[SMP_W-1:0];
        REG_ENEG: cfg.edg_neg <= bus_req.wdata[SMP_W-1:0];
        REG_DEC:  cfg.dec     <= bus_req.wdata[DEC_W-1:0];
        REG_MSK:  cfg.msk     <= bus_req.wdata[SMP_W-1:0];
        REG_POL:  cfg.pol     <= bus_req.wdata[SMP_W-1:0];
        default: ;
      endcase
    end
  end

  // control write -> event pulse in the next cycle
  always_ff @(posedge bus) begin
    if (rst) begin
      evn <= '0;
    end else if (bus_req.wen && (bus_req.addr == REG_CTL)) begin
      evn <= evn_t'(bus_req.wdata[3:0]);
    end else begin
      evn <= '0;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // read side
  ////////////////////////////////////////////////////////////////////////////

  word_t rd_mux;

  always_comb begin
    case (bus_req.addr)
      // control reads back the acquisition state
      REG_CTL:  rd_mux = word_t'(sts.state);
      REG_TEN:  rd_mux = word_t'(cfg.trg_ena);
      REG_PRE:  rd_mux = word_t'(cfg.pre);
      REG_PST:  rd_mux = word_t'(cfg.pst);
      // status counters, overflow in bit 31
      REG_SPRE: rd_mux = {sts.pro, sts.pre};
      REG_SPST: rd_mux = {sts.pso, sts.pst};
      REG_CMSK: rd_mux = word_t'(cfg.cmp_msk);
      REG_CVAL: rd_mux = word_t'(cfg.cmp_val);
      REG_EPOS: rd_mux = word_t'(cfg.edg_pos);
      REG_ENEG: rd_mux = word_t'(cfg.edg_neg);
      REG_DEC:  rd_mux = word_t'(cfg.dec);
      REG_MSK:  rd_mux = word_t'(cfg.msk);
      REG_POL:  rd_mux = word_t'(cfg.pol);
      default:  rd_mux = '0;
    endcase
  end

  // read data captured every cycle, only meaningful with ack
  always_ff @(posedge bus) begin
    bus_rsp.rdata <= rd_mux;
    if (rst) begin
      bus_rsp.ack <= 1'b0;
    end else begin
      bus_rsp.ack <= bus_req.wen | bus_req.ren;
    end
  end

  // interrupt one cycle after the last beat of a record
  always_ff @(posedge bus) begin
    if (rst) begin
      irq <= 1'b0;
    end else begin
      irq <= lst;
    end
  end

endmodule

//--- hdl/la_trigger.sv
// trigger detection on the conditioned stream
// trg = pattern match AND edge hit, edge hit is true when both edge masks are 0
// previous sample starts at zero after reset or rst event

`timescale 1ns/1ns

module la_trigger import la_pkg::*; (
  input  logic     bus,
  input  logic     rst,
  input  evn_t     evn,
  input  cfg_t     cfg,
  input  smp_str_t sti,
  output trg_str_t sto
);

  smp_t prv;
  logic cmp;
  logic edg_hit;

  // masked compare
  assign cmp = ((sti.data ^ cfg.cmp_val) & cfg.cmp_msk) == '0;

  // rising bits in edg_pos, falling bits in edg_neg
  assign edg_hit = |(cfg.edg_pos &  sti.data & ~prv)
                 | |(cfg.edg_neg & ~sti.data &  prv)
                 | ~|{cfg.edg_pos, cfg.edg_neg};

  // previous valid sample
  always_ff @(posedge bus) begin
    if (rst || evn.rst) begin
      prv <= '0;
    end else if (sti.vld) begin
      prv <= sti.data;
    end
  end

  // registered beat with trigger flag
  always_ff @(posedge bus) begin
    sto.data <= sti.data;
    sto.trg  <= cmp & edg_hit;
    if (rst) begin
      sto.vld <= 1'b0;
    end else begin
      sto.vld <= sti.vld;
    end
  end

endmodule

//--- run.sh
#!/bin/sh
# build the la_tb simulation with Verilator, run it and look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal -f src.f --top-module la_tb -o la_sim &&
./obj_dir/la_sim | tee /dev/stderr | grep -qx "ALL CHECKS PASSED" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

//--- sim/la_tb.sv
// directed testbench for the logic analyzer top level
// stimulus from a 16-bit Fibonacci LFSR and inputs change on the falling edge
// records are built with stream gaps around every bus control write
// outputs sampled on the falling edge against beats from a sample model

`timescale 1ns/1ns

module la_tb import la_pkg::*; ();

  logic     bus;
  logic     rst;
  bus_req_t bus_req;
  bus_rsp_t bus_rsp;
  smp_str_t sti;
  out_str_t sto;
  logic     irq;

  int          errors;
  logic [15:0] lfsr;
  // configuration of the running test that the model also reads
  cfg_t        mcfg;

  // valid samples driven, beats seen, beats expected
  smp_t sent[$];
  smp_t got_data[$];
  logic got_lst[$];
  smp_t exp_data[$];
  logic exp_lst[$];
  int   irq_cnt;
  logic lst_seen;

  la UUT (
    .bus     (bus),
    .rst     (rst),
    .bus_req (bus_req),
    .bus_rsp (bus_rsp),
    .sti     (sti),
    .sto     (sto),
    .irq     (irq)
  );

  always #10 bus = ~bus;

  ////////////////////////////////////////////////////////////////////////////
  // compare tasks and stimulus helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_word(input word_t got, input word_t exp, input string msg);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t ns: %s, got %h expected %h", $time, msg, got, exp);
      errors++;
    end
  endtask

  task automatic check_smp(input smp_t got, input smp_t exp, input string msg);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t ns: %s, got %h expected %h", $time, msg, got, exp);
      errors++;
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string msg);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t ns: %s, got %b expected %b", $time, msg, got, exp);
      errors++;
    end
  endtask

  // taps 16, 14, 13, 11
  function automatic logic next_bit();
    lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
    return lfsr[0];
  endfunction

  // one access with ack expected exactly one cycle after the strobe
  task automatic bus_access(input adr_t addr, input word_t wdata, input logic wr,
                            output word_t rdata);
    int n;
    @(negedge bus);
    check_flag(bus_rsp.ack, 1'b0, $sformatf("ack low before access at %h", addr));
    bus_req.addr  = addr;
    bus_req.wdata = wdata;
    bus_req.wen   = wr;
    bus_req.ren   = !wr;
    @(negedge bus);
    bus_req.wen = 1'b0;
    bus_req.ren = 1'b0;
    n = 1;
    while (!bus_rsp.ack && n < 16) begin
      @(negedge bus);
      n++;
    end
    if (!bus_rsp.ack) begin
      $display("error: no bus ack for address %h within %0d cycles", addr, n);
      errors++;
    end else begin
      check_word(word_t'(n), 32'd1, $sformatf("ack latency at address %h", addr));
    end
    rdata = bus_rsp.rdata;
  endtask

  task automatic bus_write(input adr_t addr, input word_t wdata);
    word_t unused;
    bus_access(addr, wdata, 1'b1, unused);
  endtask

  task automatic bus_read(input adr_t addr, output word_t rdata);
    bus_access(addr, '0, 1'b0, rdata);
  endtask

  task automatic apply_config();
    bus_write(REG_TEN, word_t'(mcfg.trg_ena));
    bus_write(REG_PRE, word_t'(mcfg.pre));
    bus_write(REG_PST, word_t'(mcfg.pst));
    bus_write(REG_CMSK, word_t'(mcfg.cmp_msk));
    bus_write(REG_CVAL, word_t'(mcfg.cmp_val));
    bus_write(REG_EPOS, word_t'(mcfg.edg_pos));
    bus_write(REG_ENEG, word_t'(mcfg.edg_neg));
    bus_write(REG_DEC, word_t'(mcfg.dec));
    bus_write(REG_MSK, word_t'(mcfg.msk));
    bus_write(REG_POL, word_t'(mcfg.pol));
  endtask

  // rst event then start and an optional swt while armed
  task automatic start_record(input logic sw);
    bus_write(REG_CTL, 32'h1);
    bus_write(REG_CTL, 32'h2);
    if (sw) begin
      bus_write(REG_CTL, 32'h8);
    end
  endtask

  task automatic clear_monitor();
    sent.delete();
    got_data.delete();
    got_lst.delete();
    irq_cnt = 0;
  endtask

  // vld bit first, then data msb first
  task automatic send_samples(input int cycles, input logic keep);
    smp_t d;
    logic v;
    int   i;
    int   b;
    for (i = 0; i < cycles; i++) begin
      @(negedge bus);
      v = next_bit();
      d = '0;
      for (b = 0; b < int'(SMP_W); b++) begin
        d = {d[SMP_W-2:0], next_bit()};
      end
      sti.vld  = v;
      sti.data = d;
      if (v && keep) begin
        sent.push_back(d);
      end
    end
    @(negedge bus);
    sti.vld = 1'b0;
  endtask

  // pipeline drained once sto and irq stay low for 4 cycles
  task automatic wait_quiet();
    int n;
    int quiet;
    n = 0;
    quiet = 0;
    while (quiet < 4 && n < 64) begin
      @(negedge bus);
      n++;
      quiet = (sto.vld || irq) ? 0 : quiet + 1;
    end
    if (quiet < 4) begin
      $display("error: output stream did not go quiet within %0d cycles", n);
      errors++;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // reference model and monitor
  ////////////////////////////////////////////////////////////////////////////

  // decimation, condition, trigger and record rules on the sent samples
  task automatic build_expected(input logic sw, output int tidx, output logic done);
    smp_t c;
    smp_t prv;
    dec_t skip;
    logic hit;
    logic edg;
    int   pos;
    int   left;
    int   phase;
    exp_data.delete();
    exp_lst.delete();
    prv = '0;
    skip = '0;
    pos = 0;
    left = 0;
    phase = 0;
    tidx = -1;
    foreach (sent[i]) begin
      if (skip != '0) begin
        skip = skip - dec_t'(1);
      end else begin
        skip = mcfg.dec;
        c = (sent[i] & mcfg.msk) ^ mcfg.pol;
        hit = (c & mcfg.cmp_msk) == (mcfg.cmp_val & mcfg.cmp_msk);
        edg = ((mcfg.edg_pos & c & ~prv) != '0) || ((mcfg.edg_neg & ~c & prv) != '0)
           || ((mcfg.edg_pos == '0) && (mcfg.edg_neg == '0));
        prv = c;
        // phase 0 before trigger, 1 post-trigger, 2 record closed
        if (phase < 2) begin
          exp_data.push_back(c);
          exp_lst.push_back(1'b0);
          if (phase == 1) begin
            left--;
          end else if (pos >= int'(mcfg.pre) && ((mcfg.trg_ena && hit && edg)
                       || (sw && pos == int'(mcfg.pre)))) begin
            tidx = pos;
            phase = 1;
            left = int'(mcfg.pst);
          end
          if (phase == 1 && left == 0) begin
            exp_lst[exp_lst.size()-1] = 1'b1;
            phase = 2;
          end
          pos++;
        end
      end
    end
    done = (phase == 2);
  endtask

  always @(negedge bus) begin
    if (!rst) begin
      if (irq) begin
        irq_cnt++;
        check_flag(lst_seen, 1'b1, "irq one cycle after lst");
      end
      lst_seen = sto.vld && sto.lst;
      if (sto.vld) begin
        got_data.push_back(sto.data);
        got_lst.push_back(sto.lst);
      end
    end
  end

  task automatic compare_record(input string name);
    int i;
    check_word(word_t'(got_data.size()), word_t'(exp_data.size()), {name, " beat count"});
    for (i = 0; i < got_data.size() && i < exp_data.size(); i++) begin
      check_smp(got_data[i], exp_data[i], $sformatf("%s beat %0d data", name, i));
      check_flag(got_lst[i], exp_lst[i], $sformatf("%s beat %0d lst", name, i));
    end
  endtask

  task automatic run_record(input string name, input logic sw, input int cycles,
                            output int tidx);
    logic done;
    apply_config();
    start_record(sw);
    clear_monitor();
    send_samples(cycles, 1'b1);
    wait_quiet();
    build_expected(sw, tidx, done);
    compare_record(name);
    check_flag(done, 1'b1, {name, " record closes in the model"});
    check_word(word_t'(irq_cnt), 32'd1, {name, " irq pulses"});
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic test_registers();
    adr_t  regs [10];
    word_t msks [10];
    adr_t  holes [4];
    word_t rd;
    int    i;
    regs  = '{REG_TEN, REG_PRE, REG_PST, REG_CMSK, REG_CVAL,
              REG_EPOS, REG_ENEG, REG_DEC, REG_MSK, REG_POL};
    msks  = '{32'h1, 32'h7fff_ffff, 32'h7fff_ffff, 32'hff, 32'hff,
              32'hff, 32'hff, 32'h1_ffff, 32'hff, 32'hff};
    holes = '{7'h08, 7'h0c, 7'h34, 7'h7c};
    bus_read(REG_CTL, rd);
    check_word(rd, 32'd0, "state idle after reset");
    for (i = 0; i < 10; i++) begin
      bus_write(regs[i], 32'hc3a5_9617 + 32'h1357_9bdf * i);
    end
    for (i = 0; i < 10; i++) begin
      bus_read(regs[i], rd);
      check_word(rd, (32'hc3a5_9617 + 32'h1357_9bdf * i) & msks[i],
                 $sformatf("readback at %h", regs[i]));
    end
    for (i = 0; i < 4; i++) begin
      bus_read(holes[i], rd);
      check_word(rd, 32'd0, $sformatf("unmapped read at %h", holes[i]));
    end
  endtask

  task automatic test_decimation();
    int    tidx;
    word_t rd;
    mcfg = '0;
    mcfg.dec = 17'd2;
    mcfg.msk = 8'hf6;
    mcfg.pol = 8'h3c;
    mcfg.pst = 31'd4;
    run_record("decimation", 1'b1, 60, tidx);
    // swt while armed with pre 0 leaves no pre-trigger samples
    bus_read(REG_SPRE, rd);
    check_word(rd, 32'd0, "swt takes the first sample");
  endtask

  // pattern trigger plus status readback of the same record
  task automatic test_pattern();
    int    tidx;
    word_t rd;
    mcfg = '0;
    mcfg.msk = 8'hff;
    mcfg.pre = 31'd4;
    mcfg.pst = 31'd5;
    mcfg.cmp_msk = 8'h03;
    mcfg.cmp_val = 8'h01;
    mcfg.trg_ena = 1'b1;
    run_record("pattern", 1'b0, 80, tidx);
    check_flag(tidx >= 4, 1'b1, "pattern trigger after pre samples");
    bus_read(REG_SPRE, rd);
    check_word(rd, word_t'(tidx), "pre status count");
    check_flag(rd[31], 1'b0, "pre overflow clear");
    bus_read(REG_SPST, rd);
    check_word(rd, word_t'(exp_data.size() - tidx - 1), "post status count");
    check_flag(rd[31], 1'b0, "post overflow clear");
  endtask

  task automatic test_edges();
    int tidx;
    mcfg = '0;
    mcfg.msk = 8'hff;
    mcfg.pre = 31'd2;
    mcfg.pst = 31'd3;
    mcfg.trg_ena = 1'b1;
    mcfg.edg_pos = 8'h10;
    run_record("rising edge", 1'b0, 60, tidx);
    check_flag(tidx >= 2, 1'b1, "rising edge trigger found");
    mcfg.edg_pos = 8'h00;
    mcfg.edg_neg = 8'h04;
    run_record("falling edge", 1'b0, 60, tidx);
    check_flag(tidx >= 2, 1'b1, "falling edge trigger found");
  endtask

  // stp ends an untriggered record without lst
  task automatic test_stop();
    int    tidx;
    logic  done;
    word_t rd;
    mcfg = '0;
    mcfg.msk = 8'hff;
    mcfg.pre = 31'd2;
    apply_config();
    start_record(1'b0);
    clear_monitor();
    send_samples(30, 1'b1);
    wait_quiet();
    bus_read(REG_CTL, rd);
    check_word(rd, word_t'(ACQ_ARM), "state armed before stop");
    bus_write(REG_CTL, 32'h4);
    bus_read(REG_CTL, rd);
    check_word(rd, 32'd0, "state idle after stop");
    send_samples(30, 1'b0);
    wait_quiet();
    build_expected(1'b0, tidx, done);
    compare_record("stop");
    check_word(word_t'(irq_cnt), 32'd0, "no irq after stop");
  endtask

  initial begin
    bus = 1'b0;
    rst = 1'b1;
    bus_req = '0;
    sti = '0;
    errors = 0;
    irq_cnt = 0;
    lst_seen = 1'b0;
    lfsr = 16'd51444;
    mcfg = '0;
    repeat (8) @(posedge bus);
    @(negedge bus);
    rst = 1'b0;
    test_registers();
    test_decimation();
    test_pattern();
    test_edges();
    test_stop();
    $display("simulation done, %0d errors", errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

//--- src.f
common/la_pkg.sv
hdl/la_regs.sv
hdl/la_dec.sv
hdl/la_trigger.sv
acq/la_acq.sv
hdl/la.sv
sim/la_tb.sv
